//--- source/conv_feed_pkg.sv
package conv_feed_pkg;

	localparam int mem_width    = 80;                     // columns per tile
	localparam int mem_rows     = 8;                      // rows per tile
	localparam int tap_count    = 9;                      // 3x3 taps, also write lanes
	localparam int map_width    = 16;                     // even, <= 68
	localparam int map_height   = 8;                      // even, <= mem_rows
	localparam int bias_col     = mem_width;              // one past the data columns
	localparam int weight_col   = mem_width - tap_count;  // last nine-column group
	localparam int input_groups = 8;                      // nine-column groups per row

	// bias rows + weight rows + input rows of groups
	localparam int load_cycles  = 2 * mem_rows + mem_rows * input_groups;
	// row pairs * column pairs * quadrants
	localparam int scan_cycles  = (map_height / 2) * (map_width / 2) * 4;

	typedef logic [$clog2(mem_width + 1)-1:0] col_t;  // reaches bias_col
	typedef logic [$clog2(mem_rows)-1:0]      row_t;
	typedef logic [tap_count-1:0]             lane_mask_t;  // bit 8 is tap 0
	typedef logic [1:0]                       quad_t;       // pooling quadrant

	typedef enum logic [1:0] {
		ph_idle,
		ph_load,
		ph_scan,
		ph_done
	} phase_t;

	// one memory write, lanes all zero means no write
	typedef struct packed {
		col_t       col;
		row_t       row;
		lane_mask_t lanes;
	} write_slot_t;

	typedef struct packed {
		col_t cx;  // window centre column
		row_t cy;  // window centre row
	} center_t;

	// tap_w[0] / tap_h[0] is tap 0, same tap as en[8]
	typedef struct packed {
		col_t [0:tap_count-1] tap_w;
		row_t [0:tap_count-1] tap_h;
		lane_mask_t           en;     // zero-padding enables
	} tap_bundle_t;

endpackage

//--- source/feed_control.sv
`timescale 1ns/100ps

module feed_control (
	input  logic clk,
	input  logic reset,
	input  logic start,      // only looked at in idle
	input  logic load_last,  // loader on its final slot
	input  logic scan_last,  // scanner emitted final centre
	output logic load_run,
	output logic scan_run,
	output logic done
);

	conv_feed_pkg::phase_t phase;

	assign load_run = (phase == conv_feed_pkg::ph_load);  // level for the loader
	assign scan_run = (phase == conv_feed_pkg::ph_scan);  // level for the scanner

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= conv_feed_pkg::ph_idle;
			done  <= 1'b0;
		end else begin
			done <= (phase == conv_feed_pkg::ph_done);  // lands after the last tap bundle
			case (phase)
				conv_feed_pkg::ph_idle: begin
					if (start)
						phase <= conv_feed_pkg::ph_load;
				end
				conv_feed_pkg::ph_load: begin
					if (load_last)
						phase <= conv_feed_pkg::ph_scan;  // scan starts right behind the loads
				end
				conv_feed_pkg::ph_scan: begin
					if (scan_last)
						phase <= conv_feed_pkg::ph_done;
				end
				default: begin
					phase <= conv_feed_pkg::ph_idle;  // single done cycle
				end
			endcase
		end
	end

	// the scanner only finishes inside the scan phase
	a_last_in_scan: assert property (@(posedge clk) disable iff (reset)
		scan_last |-> scan_run)
		else $error("scan_last outside the scan phase");

endmodule

//--- source/load_sequencer.sv
`timescale 1ns/100ps

module load_sequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        load_run,
	output conv_feed_pkg::write_slot_t  slot,
	output logic                        load_last
);

	logic [6:0]                 idx;        // flat slot index 0 .. load_cycles-1
	logic [6:0]                 in_idx;     // index inside the input section
	logic [2:0]                 grp;        // input group in the row
	conv_feed_pkg::write_slot_t slot_next;

	// high in the cycle that builds the final slot
	assign load_last = load_run && (idx == 7'(conv_feed_pkg::load_cycles - 1));

	assign in_idx = idx - 7'(2 * conv_feed_pkg::mem_rows);  // skip bias and weight rows
	assign grp    = 3'(in_idx % conv_feed_pkg::input_groups);

	always_comb begin
		if (idx < 7'(conv_feed_pkg::mem_rows)) begin
			slot_next.col   = conv_feed_pkg::col_t'(conv_feed_pkg::bias_col);
			slot_next.row   = conv_feed_pkg::row_t'(idx);
			slot_next.lanes = 9'b1_0000_0000;  // bias sits in lane 0 only
		end else if (idx < 7'(2 * conv_feed_pkg::mem_rows)) begin
			slot_next.col   = conv_feed_pkg::col_t'(conv_feed_pkg::weight_col);
			slot_next.row   = conv_feed_pkg::row_t'(idx);  // low bits are the row
			slot_next.lanes = '1;
		end else begin
			slot_next.col   = conv_feed_pkg::col_t'(grp * conv_feed_pkg::tap_count);
			slot_next.row   = conv_feed_pkg::row_t'(in_idx / conv_feed_pkg::input_groups);
			slot_next.lanes = '1;
			// lane 8 of the last group would hit the weight column
			if (grp == 3'(conv_feed_pkg::input_groups - 1))
				slot_next.lanes[0] = 1'b0;
		end
		if (!load_run)
			slot_next.lanes = '0;  // no write outside a run
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idx        <= '0;
			slot.lanes <= '0;
		end else begin
			slot <= slot_next;
			if (load_run)
				idx <= load_last ? 7'd0 : idx + 7'd1;  // rearmed for the next run
		end
	end

	// writes stop once the final slot has gone out
	a_no_write_after_last: assert property (@(posedge clk) disable iff (reset)
		load_last |-> ##2 (slot.lanes == '0))
		else $error("write lanes still set after the final slot");

endmodule

//--- source/window_scanner.sv
`timescale 1ns/100ps

module window_scanner (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    scan_run,
	output conv_feed_pkg::center_t  center,
	output logic                    center_valid,
	output logic                    scan_last  // with the final centre
);

	conv_feed_pkg::row_t  j;  // row pair, steps by 2
	conv_feed_pkg::col_t  k;  // column pair, steps by 2
	conv_feed_pkg::quad_t l;  // quadrant, fastest
	logic                 emit;
	logic                 l_end;
	logic                 k_end;
	logic                 j_end;
	logic                 dw;
	logic                 dh;

	// scan_last still high while control leaves ph_scan, hold off then
	assign emit  = scan_run && !scan_last;
	assign l_end = (l == 2'd3);
	assign k_end = (k == conv_feed_pkg::col_t'(conv_feed_pkg::map_width - 2));
	assign j_end = (j == conv_feed_pkg::row_t'(conv_feed_pkg::map_height - 2));

	// quadrant walk (0,0) (0,1) (1,1) (1,0) as dw,dh
	assign dw = l[1];         // l = 2, 3
	assign dh = l[1] ^ l[0];  // l = 1, 2

	always_ff @(posedge clk) begin
		if (reset) begin
			j            <= '0;
			k            <= '0;
			l            <= '0;
			center_valid <= 1'b0;
			scan_last    <= 1'b0;
		end else begin
			center_valid <= emit;
			scan_last    <= emit && l_end && k_end && j_end;
			if (emit) begin
				l <= l + 2'd1;  // wraps to 0 after quadrant 3
				if (l_end)
					k <= k_end ? '0 : k + conv_feed_pkg::col_t'(2);
				if (l_end && k_end)
					j <= j_end ? '0 : j + conv_feed_pkg::row_t'(2);
			end
		end
	end

	// centre payload, no reset
	always_ff @(posedge clk) begin
		if (emit) begin
			center.cx <= k + conv_feed_pkg::col_t'(dw);
			center.cy <= j + conv_feed_pkg::row_t'(dh);
		end
	end

	a_center_in_map: assert property (@(posedge clk) disable iff (reset)
		center_valid |-> (int'(center.cx) < conv_feed_pkg::map_width &&
			int'(center.cy) < conv_feed_pkg::map_height))
		else $error("window centre outside the feature map");

endmodule

//--- source/tap_generator.sv
`timescale 1ns/100ps

module tap_generator (
	input  logic                        clk,
	input  logic                        reset,
	input  conv_feed_pkg::center_t      center,
	input  logic                        center_valid,
	output conv_feed_pkg::tap_bundle_t  taps,
	output logic                        en_pe  // one window per cycle
);

	conv_feed_pkg::tap_bundle_t taps_next;

	// tap t sits at row offset t/3-1 and column offset t%3-1
	always_comb begin
		int nx;
		int ny;
		taps_next = '0;  // disabled taps read address zero
		for (int t = 0; t < conv_feed_pkg::tap_count; t++) begin
			nx = int'(center.cx) + (t % 3) - 1;
			ny = int'(center.cy) + (t / 3) - 1;
			// zero padding keeps only neighbours inside the map
			if (center_valid && nx >= 0 && nx < conv_feed_pkg::map_width &&
				ny >= 0 && ny < conv_feed_pkg::map_height) begin
				taps_next.en[conv_feed_pkg::tap_count-1-t] = 1'b1;  // msb is tap 0
				taps_next.tap_w[t] = conv_feed_pkg::col_t'(nx);
				taps_next.tap_h[t] = conv_feed_pkg::row_t'(ny);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			taps  <= '0;
			en_pe <= 1'b0;
		end else begin
			taps  <= taps_next;
			en_pe <= center_valid;  // aligned with the bundle
		end
	end

	// a live window always reads its own centre
	a_center_tap_live: assert property (@(posedge clk) disable iff (reset)
		en_pe |-> taps.en[conv_feed_pkg::tap_count/2])
		else $error("window without its centre tap");

endmodule

//--- source/conv_feed.sv
`timescale 1ns/100ps

module conv_feed (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,  // pulse, only taken when idle
	output conv_feed_pkg::write_slot_t  slot,   // load phase writes
	output conv_feed_pkg::tap_bundle_t  taps,   // scan phase reads
	output logic                        en_pe,
	output logic                        done
);

	logic                   load_run;
	logic                   load_last;
	logic                   scan_run;
	logic                   scan_last;
	conv_feed_pkg::center_t center;
	logic                   center_valid;

	feed_control feed_control_inst (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.load_last (load_last),
		.scan_last (scan_last),
		.load_run  (load_run),
		.scan_run  (scan_run),
		.done      (done)
	);

	load_sequencer load_sequencer_inst (
		.clk       (clk),
		.reset     (reset),
		.load_run  (load_run),
		.slot      (slot),
		.load_last (load_last)
	);

	window_scanner window_scanner_inst (
		.clk          (clk),
		.reset        (reset),
		.scan_run     (scan_run),
		.center       (center),
		.center_valid (center_valid),
		.scan_last    (scan_last)
	);

	// one cycle behind the centres
	tap_generator tap_generator_inst (
		.clk          (clk),
		.reset        (reset),
		.center       (center),
		.center_valid (center_valid),
		.taps         (taps),
		.en_pe        (en_pe)
	);

endmodule

//--- sim/conv_feed_ref.svh
`ifndef conv_feed_ref_svh
`define conv_feed_ref_svh

// slot number index of one run: bias rows, weight rows, then input rows of groups
function automatic conv_feed_pkg::write_slot_t expected_slot(input int index);
	conv_feed_pkg::write_slot_t s;
	int in_index;
	int group;
	s       = '0;
	s.lanes = '1;  // all nine lanes unless a rule says otherwise
	if (index < conv_feed_pkg::mem_rows) begin
		s.col   = conv_feed_pkg::col_t'(conv_feed_pkg::bias_col);
		s.row   = conv_feed_pkg::row_t'(index);
		s.lanes = 9'h100;  // tap 0 lane only
	end else if (index < 2 * conv_feed_pkg::mem_rows) begin
		s.col = conv_feed_pkg::col_t'(conv_feed_pkg::weight_col);
		s.row = conv_feed_pkg::row_t'(index - conv_feed_pkg::mem_rows);
	end else begin
		in_index = index - 2 * conv_feed_pkg::mem_rows;
		group    = in_index % conv_feed_pkg::input_groups;
		s.col    = conv_feed_pkg::col_t'(group * conv_feed_pkg::tap_count);
		s.row    = conv_feed_pkg::row_t'(in_index / conv_feed_pkg::input_groups);
		if (group == conv_feed_pkg::input_groups - 1)
			s.lanes[0] = 1'b0;  // last group drops its top lane
	end
	return s;
endfunction

// window number window_index of one run, quadrant fastest, then column pair, row pair
function automatic conv_feed_pkg::tap_bundle_t expected_taps(input int window_index);
	conv_feed_pkg::tap_bundle_t b;
	int quad;
	int col_pair;
	int row_pair;
	int cx;
	int cy;
	int nx;
	int ny;
	b        = '0;  // padded taps stay at zero
	quad     = window_index % 4;
	col_pair = (window_index / 4) % (conv_feed_pkg::map_width / 2);
	row_pair = window_index / (4 * (conv_feed_pkg::map_width / 2));
	cx       = 2 * col_pair + ((quad == 2 || quad == 3) ? 1 : 0);
	cy       = 2 * row_pair + ((quad == 1 || quad == 2) ? 1 : 0);
	for (int t = 0; t < conv_feed_pkg::tap_count; t++) begin
		nx = cx + (t % 3) - 1;
		ny = cy + (t / 3) - 1;
		if (nx >= 0 && nx < conv_feed_pkg::map_width && ny >= 0 &&
			ny < conv_feed_pkg::map_height) begin
			b.en[conv_feed_pkg::tap_count-1-t] = 1'b1;  // en msb is tap 0
			b.tap_w[t] = conv_feed_pkg::col_t'(nx);
			b.tap_h[t] = conv_feed_pkg::row_t'(ny);
		end
	end
	return b;
endfunction

`endif

//--- sim/conv_feed_tb.sv
`timescale 1ns/100ps

module conv_feed_tb;

	`include "conv_feed_ref.svh"

	localparam int reset_cycles   = 16;
	localparam int timeout_cycles = 520;  // 16 + 2*(15+211) plus margin
	localparam int midrun_gap     = 40;   // stray start lands in the load phase
	localparam int runs           = 2;
	localparam int scan_first     = conv_feed_pkg::load_cycles + 2;  // first en_pe cycle
	localparam int done_cycle     = scan_first + conv_feed_pkg::scan_cycles;

	logic                       clk;
	logic                       reset;
	logic                       start;
	conv_feed_pkg::write_slot_t slot;
	conv_feed_pkg::tap_bundle_t taps;
	logic                       en_pe;
	logic                       done;

	integer seed;
	int     gap;
	int     cycle_count;
	int     run_cycle;    // edges since start was taken
	int     run_index;
	bit     busy;         // expected run in flight
	int     slot_errors;
	int     tap_errors;
	int     flag_errors;
	int     count_errors;
	int     slot_writes;
	int     windows;
	int     done_count;

	conv_feed conv_feed_inst (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.slot  (slot),
		.taps  (taps),
		.en_pe (en_pe),
		.done  (done)
	);

	always #50 clk = ~clk;  // 100 ns period

	// address is a don't care when no lane writes
	task automatic check_slot(input string name, input conv_feed_pkg::write_slot_t exp,
		input conv_feed_pkg::write_slot_t act);
		if (exp.lanes == '0) begin
			if (act.lanes !== exp.lanes) begin
				$display("mismatch %s lanes expected %h actual %h", name, exp.lanes, act.lanes);
				slot_errors = slot_errors + 1;
			end
		end else if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			slot_errors = slot_errors + 1;
		end
	endtask

	task automatic check_taps(input string name, input conv_feed_pkg::tap_bundle_t exp,
		input conv_feed_pkg::tap_bundle_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			tap_errors = tap_errors + 1;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			flag_errors = flag_errors + 1;
		end
	endtask

	// outputs read at the edge hold what the previous edge registered
	always @(posedge clk) begin : compare_outputs
		int                         obs;
		string                      tag;
		conv_feed_pkg::write_slot_t exp_slot;
		conv_feed_pkg::tap_bundle_t exp_taps;
		if (reset) begin
			busy = 1'b0;
		end else begin
			if (busy)
				run_cycle = run_cycle + 1;
			obs      = busy ? run_cycle - 1 : -1;  // cycle after the start edge
			tag      = $sformatf("run %0d cycle %0d", run_index, obs);
			exp_slot = '0;
			exp_taps = '0;
			if (obs >= 1 && obs <= conv_feed_pkg::load_cycles)
				exp_slot = expected_slot(obs - 1);
			if (obs >= scan_first && obs < done_cycle)
				exp_taps = expected_taps(obs - scan_first);
			check_slot({tag, " slot"}, exp_slot, slot);
			check_taps({tag, " taps"}, exp_taps, taps);
			check_flag({tag, " en_pe"}, obs >= scan_first && obs < done_cycle, en_pe);
			check_flag({tag, " done"}, obs == done_cycle, done);
			if (|slot.lanes)
				slot_writes = slot_writes + 1;
			if (en_pe)
				windows = windows + 1;
			if (done)
				done_count = done_count + 1;
			if (obs == done_cycle)
				busy = 1'b0;  // idle again, start can be taken this edge
			if (!busy && start) begin
				busy      = 1'b1;
				run_cycle = 0;
				run_index = run_index + 1;
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout, run still going after %0d cycles", cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	// drive on the falling edge
	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		start        = 1'b0;
		seed         = 66;
		cycle_count  = 0;
		run_cycle    = 0;
		run_index    = 0;
		busy         = 1'b0;
		slot_errors  = 0;
		tap_errors   = 0;
		flag_errors  = 0;
		count_errors = 0;
		slot_writes  = 0;
		windows      = 0;
		done_count   = 0;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < runs; r++) begin
			gap = {$random(seed)} % 16;  // idle gap 0..15
			repeat (gap + 1) @(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			repeat (midrun_gap) @(negedge clk);
			start = 1'b1;  // busy, must be ignored
			@(negedge clk);
			start = 1'b0;
			while (done !== 1'b1)
				@(negedge clk);
		end
		repeat (8) @(negedge clk);  // quiet tail after the last done
		if (slot_writes != runs * conv_feed_pkg::load_cycles) begin
			$display("wrong number of write slots, saw %0d", slot_writes);
			count_errors = count_errors + 1;
		end
		if (windows != runs * conv_feed_pkg::scan_cycles) begin
			$display("wrong number of tap bundles, saw %0d", windows);
			count_errors = count_errors + 1;
		end
		if (done_count != runs) begin
			$display("wrong number of done pulses, saw %0d", done_count);
			count_errors = count_errors + 1;
		end
		$display("errors: slot %0d, taps %0d, flags %0d, counts %0d",
			slot_errors, tap_errors, flag_errors, count_errors);
		if (slot_errors + tap_errors + flag_errors + count_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- Makefile
VERILATOR ?= verilator
TOP       ?= conv_feed_tb
FILELIST  ?= conv_feed.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard sim/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- conv_feed.f
source/conv_feed_pkg.sv
source/feed_control.sv
source/load_sequencer.sv
source/window_scanner.sv
source/tap_generator.sv
source/conv_feed.sv
sim/conv_feed_tb.sv
+incdir+sim
